//--- common/mips_mem_macros.svh
`ifndef MIPS_MEM_MACROS_SVH
`define MIPS_MEM_MACROS_SVH

// data bus and pipeline word width
`define MEM_DATA_W 32

// word address bits of the data RAM (1024 words)
`define MEM_RAM_AW 10

// cycles between address acceptance and rvalid/bvalid
`define MEM_RAM_DELAY 2

`endif

//--- common/mips_mem_pkg.sv
`default_nettype none

`include "mips_mem_macros.svh"

package mips_mem_pkg;

	typedef logic [`MEM_DATA_W-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	// one bit per byte lane, register writeback or bus strobe
	typedef logic [3:0] byte_en_t;

	typedef enum logic [3:0] {
		op_none,
		op_lb,
		op_lbu,
		op_lh,
		op_lhu,
		op_lw,
		op_lwl,
		op_lwr,
		op_sb,
		op_sh,
		op_sw
	} mem_op_t;

	// addr covers both the address and the write data phase
	typedef enum logic [1:0] {
		idle,
		addr,
		resp
	} dbus_state_t;

	function automatic logic is_load(mem_op_t op);
		return (op == op_lb) || (op == op_lbu) || (op == op_lh) || (op == op_lhu) ||
			(op == op_lw) || (op == op_lwl) || (op == op_lwr);
	endfunction

	function automatic logic is_store(mem_op_t op);
		return (op == op_sb) || (op == op_sh) || (op == op_sw);
	endfunction

endpackage

`default_nettype wire

//--- mem_stage/mem_load_align.sv
`timescale 1ns/1ns
`default_nettype none

module mem_load_align
	import mips_mem_pkg::*;
(
	input  wire mem_op_t  mem_op_i,
	input  wire [1:0]     addr_low_i,
	input  wire word_t    rdata_i,

	output word_t         load_data_o,
	output byte_en_t      merge_wren_o
);

	logic [7:0]  byte_sel;
	logic [15:0] half_sel;
	logic [4:0]  lane_shift;
	logic [4:0]  left_shift;

	// bit offset of the addressed byte lane
	assign lane_shift = {addr_low_i, 3'b000};
	// lwl moves the addressed byte up to lane 3
	assign left_shift = {~addr_low_i, 3'b000};

	assign byte_sel = rdata_i[lane_shift +: 8];
	assign half_sel = addr_low_i[1] ? rdata_i[31:16] : rdata_i[15:0];

	always_comb begin
		load_data_o  = rdata_i;
		merge_wren_o = 4'b1111;
		case (mem_op_i)
			op_lb: begin
				load_data_o = {{24{byte_sel[7]}}, byte_sel};
			end
			op_lbu: begin
				load_data_o = {24'b0, byte_sel};
			end
			op_lh: begin
				load_data_o = {{16{half_sel[15]}}, half_sel};
			end
			op_lhu: begin
				load_data_o = {16'b0, half_sel};
			end
			op_lwl: begin
				// loaded bytes land in the upper lanes, low lanes keep the register
				load_data_o  = rdata_i << left_shift;
				merge_wren_o = 4'b1111 << ~addr_low_i;
			end
			op_lwr: begin
				// loaded bytes land in the lower lanes
				load_data_o  = rdata_i >> lane_shift;
				merge_wren_o = 4'b1111 >> addr_low_i;
			end
			default: begin
				// lw and non-load ops take the word as is
				load_data_o  = rdata_i;
				merge_wren_o = 4'b1111;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- mem_stage/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage
	import mips_mem_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n_i,

	input  wire            stall_i,
	input  wire            flush_i,
	input  wire            valid_i,

	input  wire mem_op_t   mem_op_i,
	input  wire [1:0]      addr_low_i,
	input  wire word_t     rdata_i,
	input  wire word_t     alu_result_i,
	input  wire reg_addr_t waddr_i,
	input  wire byte_en_t  wren_i,
	input  wire word_t     pc_i,

	output reg_addr_t      wb_waddr_o,
	output word_t          wb_wdata_o,
	output byte_en_t       wb_wren_o,
	output word_t          wb_pc_o,

	// forwarding path, not registered
	output word_t          bp_wdata_o
);

	word_t     load_data;
	byte_en_t  merge_wren;

	logic      bubble;
	reg_addr_t waddr_next;
	word_t     wdata_next;
	byte_en_t  wren_next;

	mem_load_align mem_load_align_i (
		.mem_op_i     (mem_op_i),
		.addr_low_i   (addr_low_i),
		.rdata_i      (rdata_i),
		.load_data_o  (load_data),
		.merge_wren_o (merge_wren)
	);

	assign bp_wdata_o = alu_result_i;

	assign bubble = flush_i | ~valid_i;

	always_comb begin
		waddr_next = waddr_i;
		wdata_next = alu_result_i;
		wren_next  = wren_i;
		if (is_load(mem_op_i)) begin
			wdata_next = load_data;
			wren_next  = merge_wren;
		end else if (is_store(mem_op_i)) begin
			// stores write no register
			wren_next = '0;
		end
		if (bubble) begin
			waddr_next = '0;
			wdata_next = '0;
			wren_next  = '0;
		end
	end

	// writeback register, frozen while the bus is busy
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_waddr_o <= '0;
			wb_wdata_o <= '0;
			wb_wren_o  <= '0;
			wb_pc_o    <= '0;
		end else if (!stall_i) begin
			wb_waddr_o <= waddr_next;
			wb_wdata_o <= wdata_next;
			wb_wren_o  <= wren_next;
			// pc follows even for a bubble
			wb_pc_o    <= pc_i;
		end
	end

	a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
		(flush_i && !stall_i) |=> (wb_wren_o == '0));

endmodule

`default_nettype wire

//--- verilog/dbus_axil_master.sv
`timescale 1ns/1ns
`default_nettype none

module dbus_axil_master
	import mips_mem_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n_i,

	input  wire           req_valid_i,
	input  wire mem_op_t  req_op_i,
	input  wire word_t    req_addr_i,
	input  wire word_t    req_store_data_i,

	output word_t         m_axil_awaddr_o,
	output logic          m_axil_awvalid_o,
	input  wire           m_axil_awready_i,
	output word_t         m_axil_wdata_o,
	output byte_en_t      m_axil_wstrb_o,
	output logic          m_axil_wvalid_o,
	input  wire           m_axil_wready_i,
	input  wire [1:0]     m_axil_bresp_i,
	input  wire           m_axil_bvalid_i,
	output logic          m_axil_bready_o,
	output word_t         m_axil_araddr_o,
	output logic          m_axil_arvalid_o,
	input  wire           m_axil_arready_i,
	input  wire word_t    m_axil_rdata_i,
	input  wire [1:0]     m_axil_rresp_i,
	input  wire           m_axil_rvalid_i,
	output logic          m_axil_rready_o,

	output word_t         rdata_o,
	output logic          stall_o
);

	dbus_state_t state_q;

	logic     mem_req;
	logic     start;
	logic     resp_done;
	logic     aw_left;
	logic     w_left;
	logic     ar_left;
	word_t    addr_q;
	word_t    wdata_q;
	byte_en_t wstrb_q;
	word_t    st_data;
	byte_en_t st_strb;

	assign mem_req = req_valid_i && (req_op_i != op_none);
	assign start   = (state_q == idle) && mem_req;

	assign m_axil_bready_o = 1'b1;
	assign m_axil_rready_o = 1'b1;

	assign resp_done = (m_axil_bvalid_i && m_axil_bready_o) ||
		(m_axil_rvalid_i && m_axil_rready_o);

	// channels still waiting for their ready after this cycle
	assign aw_left = m_axil_awvalid_o && !m_axil_awready_i;
	assign w_left  = m_axil_wvalid_o && !m_axil_wready_i;
	assign ar_left = m_axil_arvalid_o && !m_axil_arready_i;

	// stall until the response cycle so the stage captures the read data
	assign stall_o = mem_req && !((state_q == resp) && resp_done);
	assign rdata_o = m_axil_rvalid_i ? m_axil_rdata_i : '0;

	// lane replication for narrow stores
	always_comb begin
		case (req_op_i)
			op_sb: begin
				st_data = {4{req_store_data_i[7:0]}};
				st_strb = 4'b0001 << req_addr_i[1:0];
			end
			op_sh: begin
				st_data = {2{req_store_data_i[15:0]}};
				st_strb = req_addr_i[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				st_data = req_store_data_i;
				st_strb = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q  <= {req_addr_i[31:2], 2'b00};
			wdata_q <= st_data;
			wstrb_q <= st_strb;
		end
	end

	assign m_axil_awaddr_o = addr_q;
	assign m_axil_araddr_o = addr_q;
	assign m_axil_wdata_o  = wdata_q;
	assign m_axil_wstrb_o  = wstrb_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q          <= idle;
			m_axil_awvalid_o <= 1'b0;
			m_axil_wvalid_o  <= 1'b0;
			m_axil_arvalid_o <= 1'b0;
		end else begin
			case (state_q)
				idle: begin
					if (mem_req) begin
						state_q <= addr;
						if (is_store(req_op_i)) begin
							m_axil_awvalid_o <= 1'b1;
							m_axil_wvalid_o  <= 1'b1;
						end else begin
							m_axil_arvalid_o <= 1'b1;
						end
					end
				end
				addr: begin
					// aw and w may be accepted in different cycles
					m_axil_awvalid_o <= aw_left;
					m_axil_wvalid_o  <= w_left;
					m_axil_arvalid_o <= ar_left;
					if (!aw_left && !w_left && !ar_left) begin
						state_q <= resp;
					end
				end
				resp: begin
					if (resp_done) begin
						state_q <= idle;
					end
				end
				default: begin
					state_q <= idle;
				end
			endcase
		end
	end

	a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(m_axil_awvalid_o && !m_axil_awready_i) |=> m_axil_awvalid_o);
	a_w_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(m_axil_wvalid_o && !m_axil_wready_i) |=> m_axil_wvalid_o);
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(m_axil_arvalid_o && !m_axil_arready_i) |=> m_axil_arvalid_o);
	a_resp_okay: assert property (@(posedge clk) disable iff (!rst_n_i)
		(m_axil_bvalid_i || m_axil_rvalid_i) |->
		(!m_axil_bvalid_i || m_axil_bresp_i == 2'b00) &&
		(!m_axil_rvalid_i || m_axil_rresp_i == 2'b00));

endmodule

`default_nettype wire

//--- verilog/axil_data_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_mem_macros.svh"

module axil_data_ram
	import mips_mem_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n_i,

	input  wire word_t    s_axil_awaddr_i,
	input  wire           s_axil_awvalid_i,
	output logic          s_axil_awready_o,
	input  wire word_t    s_axil_wdata_i,
	input  wire byte_en_t s_axil_wstrb_i,
	input  wire           s_axil_wvalid_i,
	output logic          s_axil_wready_o,
	output logic [1:0]    s_axil_bresp_o,
	output logic          s_axil_bvalid_o,
	input  wire           s_axil_bready_i,
	input  wire word_t    s_axil_araddr_i,
	input  wire           s_axil_arvalid_i,
	output logic          s_axil_arready_o,
	output word_t         s_axil_rdata_o,
	output logic [1:0]    s_axil_rresp_o,
	output logic          s_axil_rvalid_o,
	input  wire           s_axil_rready_i
);

	localparam int DEPTH = 1 << `MEM_RAM_AW;
	localparam int CNT_W = $clog2(`MEM_RAM_DELAY + 2);
	// a delay of one raises valid straight from the accepting edge
	localparam logic FAST = (`MEM_RAM_DELAY <= 1);

	word_t mem_q [DEPTH];

	logic                   aw_held_q;
	logic                   w_held_q;
	logic [`MEM_RAM_AW-1:0] aw_idx_q;
	word_t                  w_data_q;
	byte_en_t               w_strb_q;
	logic                   busy_q;
	logic                   rd_q;
	logic [CNT_W-1:0]       cnt_q;

	logic                   aw_hs;
	logic                   w_hs;
	logic                   ar_hs;
	logic                   wr_fire;
	logic                   start;
	logic [`MEM_RAM_AW-1:0] wr_idx;
	word_t                  wr_data;
	byte_en_t               wr_strb;

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem_q[i] = '0;
		end
	end

	// one access at a time, writes win over reads
	assign s_axil_awready_o = !busy_q && !aw_held_q;
	assign s_axil_wready_o  = !busy_q && !w_held_q;
	assign s_axil_arready_o = !busy_q && !aw_held_q && !w_held_q &&
		!s_axil_awvalid_i && !s_axil_wvalid_i;

	assign aw_hs = s_axil_awvalid_i && s_axil_awready_o;
	assign w_hs  = s_axil_wvalid_i && s_axil_wready_o;
	assign ar_hs = s_axil_arvalid_i && s_axil_arready_o;

	assign wr_fire = !busy_q && (aw_held_q || aw_hs) && (w_held_q || w_hs);
	assign start   = wr_fire || ar_hs;

	assign wr_idx  = aw_held_q ? aw_idx_q : s_axil_awaddr_i[`MEM_RAM_AW+1:2];
	assign wr_data = w_held_q ? w_data_q : s_axil_wdata_i;
	assign wr_strb = w_held_q ? w_strb_q : s_axil_wstrb_i;

	assign s_axil_bresp_o = 2'b00;
	assign s_axil_rresp_o = 2'b00;

	always_ff @(posedge clk) begin
		if (aw_hs) begin
			aw_idx_q <= s_axil_awaddr_i[`MEM_RAM_AW+1:2];
		end
		if (w_hs) begin
			w_data_q <= s_axil_wdata_i;
			w_strb_q <= s_axil_wstrb_i;
		end
		if (wr_fire) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_strb[b]) begin
					mem_q[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
		// read data is sampled at address acceptance
		if (ar_hs) begin
			s_axil_rdata_o <= mem_q[s_axil_araddr_i[`MEM_RAM_AW+1:2]];
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			aw_held_q       <= 1'b0;
			w_held_q        <= 1'b0;
			busy_q          <= 1'b0;
			rd_q            <= 1'b0;
			cnt_q           <= '0;
			s_axil_bvalid_o <= 1'b0;
			s_axil_rvalid_o <= 1'b0;
		end else begin
			if (wr_fire) begin
				aw_held_q <= 1'b0;
				w_held_q  <= 1'b0;
			end else begin
				if (aw_hs) begin
					aw_held_q <= 1'b1;
				end
				if (w_hs) begin
					w_held_q <= 1'b1;
				end
			end

			if (start) begin
				busy_q <= 1'b1;
				rd_q   <= ar_hs;
				cnt_q  <= CNT_W'(`MEM_RAM_DELAY - 1);
				if (FAST) begin
					s_axil_rvalid_o <= ar_hs;
					s_axil_bvalid_o <= !ar_hs;
				end
			end else if (busy_q && !s_axil_bvalid_o && !s_axil_rvalid_o) begin
				if (cnt_q <= CNT_W'(1)) begin
					s_axil_rvalid_o <= rd_q;
					s_axil_bvalid_o <= !rd_q;
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
			end

			if ((s_axil_bvalid_o && s_axil_bready_i) || (s_axil_rvalid_o && s_axil_rready_i)) begin
				s_axil_bvalid_o <= 1'b0;
				s_axil_rvalid_o <= 1'b0;
				busy_q          <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top
	import mips_mem_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n_i,

	input  wire            req_valid_i,
	input  wire mem_op_t   req_op_i,
	input  wire word_t     req_addr_i,
	input  wire word_t     req_store_data_i,
	input  wire word_t     req_alu_result_i,
	input  wire reg_addr_t req_waddr_i,
	input  wire byte_en_t  req_wren_i,
	input  wire word_t     req_pc_i,
	input  wire            flush_i,

	output logic           stall_o,

	output reg_addr_t      wb_waddr_o,
	output word_t          wb_wdata_o,
	output byte_en_t       wb_wren_o,
	output word_t          wb_pc_o,
	output word_t          bp_wdata_o
);

	// AXI4-Lite between bus master and RAM
	word_t      axil_awaddr;
	logic       axil_awvalid;
	logic       axil_awready;
	word_t      axil_wdata;
	byte_en_t   axil_wstrb;
	logic       axil_wvalid;
	logic       axil_wready;
	logic [1:0] axil_bresp;
	logic       axil_bvalid;
	logic       axil_bready;
	word_t      axil_araddr;
	logic       axil_arvalid;
	logic       axil_arready;
	word_t      axil_rdata;
	logic [1:0] axil_rresp;
	logic       axil_rvalid;
	logic       axil_rready;

	word_t      dbus_rdata;
	logic       dbus_stall;

	assign stall_o = dbus_stall;

	dbus_axil_master dbus_axil_master_i (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.req_valid_i      (req_valid_i),
		.req_op_i         (req_op_i),
		.req_addr_i       (req_addr_i),
		.req_store_data_i (req_store_data_i),
		.m_axil_awaddr_o  (axil_awaddr),
		.m_axil_awvalid_o (axil_awvalid),
		.m_axil_awready_i (axil_awready),
		.m_axil_wdata_o   (axil_wdata),
		.m_axil_wstrb_o   (axil_wstrb),
		.m_axil_wvalid_o  (axil_wvalid),
		.m_axil_wready_i  (axil_wready),
		.m_axil_bresp_i   (axil_bresp),
		.m_axil_bvalid_i  (axil_bvalid),
		.m_axil_bready_o  (axil_bready),
		.m_axil_araddr_o  (axil_araddr),
		.m_axil_arvalid_o (axil_arvalid),
		.m_axil_arready_i (axil_arready),
		.m_axil_rdata_i   (axil_rdata),
		.m_axil_rresp_i   (axil_rresp),
		.m_axil_rvalid_i  (axil_rvalid),
		.m_axil_rready_o  (axil_rready),
		.rdata_o          (dbus_rdata),
		.stall_o          (dbus_stall)
	);

	axil_data_ram axil_data_ram_i (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.s_axil_awaddr_i  (axil_awaddr),
		.s_axil_awvalid_i (axil_awvalid),
		.s_axil_awready_o (axil_awready),
		.s_axil_wdata_i   (axil_wdata),
		.s_axil_wstrb_i   (axil_wstrb),
		.s_axil_wvalid_i  (axil_wvalid),
		.s_axil_wready_o  (axil_wready),
		.s_axil_bresp_o   (axil_bresp),
		.s_axil_bvalid_o  (axil_bvalid),
		.s_axil_bready_i  (axil_bready),
		.s_axil_araddr_i  (axil_araddr),
		.s_axil_arvalid_i (axil_arvalid),
		.s_axil_arready_o (axil_arready),
		.s_axil_rdata_o   (axil_rdata),
		.s_axil_rresp_o   (axil_rresp),
		.s_axil_rvalid_o  (axil_rvalid),
		.s_axil_rready_i  (axil_rready)
	);

	// op and low address bits come straight from the request port
	mem_stage mem_stage_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.stall_i      (dbus_stall),
		.flush_i      (flush_i),
		.valid_i      (req_valid_i),
		.mem_op_i     (req_op_i),
		.addr_low_i   (req_addr_i[1:0]),
		.rdata_i      (dbus_rdata),
		.alu_result_i (req_alu_result_i),
		.waddr_i      (req_waddr_i),
		.wren_i       (req_wren_i),
		.pc_i         (req_pc_i),
		.wb_waddr_o   (wb_waddr_o),
		.wb_wdata_o   (wb_wdata_o),
		.wb_wren_o    (wb_wren_o),
		.wb_pc_o      (wb_pc_o),
		.bp_wdata_o   (bp_wdata_o)
	);

endmodule

`default_nettype wire

//--- testbench/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_mem_macros.svh"

module tb_mem_subsys
	import mips_mem_pkg::*;
#(
	parameter int SEED = 33582
);

	typedef struct packed {
		reg_addr_t waddr;
		word_t     data;
		byte_en_t  wren;
		word_t     pc;
	} wb_entry_t;

	logic      clk;
	logic      rst_n;
	logic      req_valid;
	mem_op_t   req_op;
	word_t     req_addr;
	word_t     req_store_data;
	word_t     req_alu_result;
	reg_addr_t req_waddr;
	byte_en_t  req_wren;
	word_t     req_pc;
	logic      flush;

	logic      stall;
	reg_addr_t wb_waddr;
	word_t     wb_wdata;
	byte_en_t  wb_wren;
	word_t     wb_pc;
	word_t     bp_wdata;

	// mirror of the data RAM contents
	word_t     shadow [1 << `MEM_RAM_AW];
	wb_entry_t exp_q [$];
	word_t     addr_list [$];
	integer    seed;
	int        n_issued;
	int        cycles;
	int        fail_count;
	logic      checks_on;

	mem_subsys_top mem_subsys_top_i (
		.clk              (clk),
		.rst_n_i          (rst_n),
		.req_valid_i      (req_valid),
		.req_op_i         (req_op),
		.req_addr_i       (req_addr),
		.req_store_data_i (req_store_data),
		.req_alu_result_i (req_alu_result),
		.req_waddr_i      (req_waddr),
		.req_wren_i       (req_wren),
		.req_pc_i         (req_pc),
		.flush_i          (flush),
		.stall_o          (stall),
		.wb_waddr_o       (wb_waddr),
		.wb_wdata_o       (wb_wdata),
		.wb_wren_o        (wb_wren),
		.wb_pc_o          (wb_pc),
		.bp_wdata_o       (bp_wdata)
	);

	always #5 clk = ~clk;

	// limit grows with every issued request
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > 40 * n_issued + 100) begin
			$display("Timeout: no request accepted for too long, %0d cycles run", cycles);
			$display("TESTBENCH FAILED");
			$fatal(1, "run aborted by the cycle limit");
		end
	end

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic wb_entry_t expected_wb(mem_op_t op, word_t addr, word_t sdata,
		word_t alu, reg_addr_t waddr, byte_en_t wren, word_t mem_word);
		wb_entry_t e;
		logic [7:0]  b;
		logic [15:0] h;
		e.waddr = waddr;
		e.data  = alu;
		e.wren  = wren;
		e.pc    = '0;
		case (addr[1:0])
			2'd0: b = mem_word[7:0];
			2'd1: b = mem_word[15:8];
			2'd2: b = mem_word[23:16];
			default: b = mem_word[31:24];
		endcase
		h = addr[1] ? mem_word[31:16] : mem_word[15:0];
		case (op)
			op_lb: begin
				e.data = {{24{b[7]}}, b};
				e.wren = 4'b1111;
			end
			op_lbu: begin
				e.data = {24'h0, b};
				e.wren = 4'b1111;
			end
			op_lh: begin
				e.data = {{16{h[15]}}, h};
				e.wren = 4'b1111;
			end
			op_lhu: begin
				e.data = {16'h0, h};
				e.wren = 4'b1111;
			end
			op_lw: begin
				e.data = mem_word;
				e.wren = 4'b1111;
			end
			op_lwl: begin
				case (addr[1:0])
					2'd0: begin
						e.data = {mem_word[7:0], 24'h0};
						e.wren = 4'b1000;
					end
					2'd1: begin
						e.data = {mem_word[15:0], 16'h0};
						e.wren = 4'b1100;
					end
					2'd2: begin
						e.data = {mem_word[23:0], 8'h0};
						e.wren = 4'b1110;
					end
					default: begin
						e.data = mem_word;
						e.wren = 4'b1111;
					end
				endcase
			end
			op_lwr: begin
				case (addr[1:0])
					2'd0: begin
						e.data = mem_word;
						e.wren = 4'b1111;
					end
					2'd1: begin
						e.data = {8'h0, mem_word[31:8]};
						e.wren = 4'b0111;
					end
					2'd2: begin
						e.data = {16'h0, mem_word[31:16]};
						e.wren = 4'b0011;
					end
					default: begin
						e.data = {24'h0, mem_word[31:24]};
						e.wren = 4'b0001;
					end
				endcase
			end
			op_sb, op_sh, op_sw: begin
				e.wren = 4'b0000;
			end
			default: begin
				e.wren = wren;
			end
		endcase
		// store data only reaches the memory, never the register
		if (op inside {op_sb, op_sh, op_sw}) begin
			e.data = alu;
		end
		return e;
	endfunction

	// aligns the address as the op requires, within 2**bits bytes
	function automatic word_t pick_addr(mem_op_t op, word_t r, int bits);
		word_t a;
		a = r & ((32'd1 << bits) - 32'd1);
		if (op inside {op_lh, op_lhu, op_sh}) begin
			a[0] = 1'b0;
		end
		if (op inside {op_lw, op_sw}) begin
			a[1:0] = 2'b00;
		end
		return a;
	endfunction

	task automatic apply_store(input mem_op_t op, input word_t addr, input word_t sdata);
		logic [`MEM_RAM_AW-1:0] idx;
		idx = addr[`MEM_RAM_AW+1:2];
		case (op)
			op_sb: shadow[idx][addr[1:0]*8 +: 8] = sdata[7:0];
			op_sh: begin
				if (addr[1]) begin
					shadow[idx][31:16] = sdata[15:0];
				end else begin
					shadow[idx][15:0] = sdata[15:0];
				end
			end
			op_sw: shadow[idx] = sdata;
			default: begin
			end
		endcase
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			fail_count++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at the first error");
		end
	endtask

	// drive one request at the current rising edge, return at its accepting edge
	task automatic send_req(input logic valid, input mem_op_t op, input word_t addr,
		input word_t sdata, input logic fl);
		word_t     alu;
		word_t     r;
		word_t     pc;
		logic      busy;
		logic      first_look;
		wb_entry_t e;
		alu = rand_word();
		r   = rand_word();
		pc  = {r[31:2], 2'b00};
		req_valid      <= valid;
		req_op         <= op;
		req_addr       <= addr;
		req_store_data <= sdata;
		req_alu_result <= alu;
		req_waddr      <= r[4:0];
		req_wren       <= r[8:5];
		req_pc         <= pc;
		flush          <= fl;
		n_issued++;
		first_look = 1'b1;
		do begin
			@(negedge clk);
			busy = stall;
			if (first_look) begin
				// a valid memory op stalls at first, anything else goes on the first edge
				check_value("stall_o", word_t'(busy), word_t'(valid && (op != op_none)));
				first_look = 1'b0;
			end
			@(posedge clk);
		end while (busy);
		if (valid && !fl) begin
			e = expected_wb(op, addr, sdata, alu, r[4:0], r[8:5],
				shadow[addr[`MEM_RAM_AW+1:2]]);
		end else begin
			e = '0;
		end
		e.pc = pc;
		exp_q.push_back(e);
		if (valid) begin
			apply_store(op, addr, sdata);
		end
	endtask

	always @(negedge clk) begin : compare
		wb_entry_t e;
		if (checks_on) begin
			check_value("bp_wdata_o", bp_wdata, req_alu_result);
		end
		if (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			check_value("wb_waddr_o", word_t'(wb_waddr), word_t'(e.waddr));
			check_value("wb_wdata_o", wb_wdata, e.data);
			check_value("wb_wren_o", word_t'(wb_wren), word_t'(e.wren));
			check_value("wb_pc_o", wb_pc, e.pc);
		end
	end

	initial begin
		word_t   a;
		word_t   base;
		word_t   r;
		mem_op_t op;
		mem_op_t load_ops [7];
		logic    v;
		logic    fl;
		load_ops = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr};
		seed = SEED;
		n_issued = 0;
		cycles = 0;
		fail_count = 0;
		checks_on = 1'b0;
		clk = 1'b0;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_op = op_none;
		req_addr = '0;
		req_store_data = '0;
		req_alu_result = '0;
		req_waddr = '0;
		req_wren = '0;
		req_pc = '0;
		flush = 1'b0;
		for (int i = 0; i < (1 << `MEM_RAM_AW); i++) begin
			shadow[i] = '0;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// idle after reset
		@(negedge clk);
		checks_on = 1'b1;
		check_value("stall_o", word_t'(stall), 32'd0);
		check_value("wb_waddr_o", word_t'(wb_waddr), 32'd0);
		check_value("wb_wdata_o", wb_wdata, 32'd0);
		check_value("wb_wren_o", word_t'(wb_wren), 32'd0);
		check_value("wb_pc_o", wb_pc, 32'd0);
		@(posedge clk);

		// narrow and word stores, then read each word back
		for (int i = 0; i < 12; i++) begin
			r = rand_word();
			op = (r % 32'd3 == 0) ? op_sb : ((r % 32'd3 == 1) ? op_sh : op_sw);
			a = pick_addr(op, rand_word(), `MEM_RAM_AW + 2);
			addr_list.push_back(a);
			send_req(1'b1, op, a, rand_word(), 1'b0);
		end
		foreach (addr_list[i]) begin
			send_req(1'b1, op_lw, {addr_list[i][31:2], 2'b00}, '0, 1'b0);
		end

		// every load at every legal offset
		for (int w = 0; w < 4; w++) begin
			base = pick_addr(op_sw, rand_word(), `MEM_RAM_AW + 2);
			send_req(1'b1, op_sw, base, rand_word(), 1'b0);
			for (int off = 0; off < 4; off++) begin
				a = base + word_t'(off);
				for (int k = 0; k < 7; k++) begin
					if (pick_addr(load_ops[k], a, `MEM_RAM_AW + 2) == a) begin
						send_req(1'b1, load_ops[k], a, '0, 1'b0);
					end
				end
			end
		end

		// pass-through ALU results, some with valid low
		for (int i = 0; i < 16; i++) begin
			r = rand_word();
			send_req(r[3:0] != 4'd0, op_none, rand_word(), '0, 1'b0);
		end

		// flushed requests still perform their bus access
		send_req(1'b1, op_sw, 32'h40, 32'h1234_5678, 1'b1);
		send_req(1'b1, op_lw, 32'h40, '0, 1'b0);
		send_req(1'b1, op_lw, 32'h40, '0, 1'b1);
		send_req(1'b1, op_none, '0, '0, 1'b1);
		send_req(1'b1, op_sb, 32'h41, 32'h0000_00ab, 1'b1);
		send_req(1'b1, op_lw, 32'h40, '0, 1'b0);

		// mixed traffic over a small window so loads hit earlier stores
		for (int i = 0; i < 80; i++) begin
			r = rand_word();
			op = mem_op_t'(4'(r % 32'd11));
			v = (r[7:4] != 4'd0);
			fl = (r[11:8] == 4'd0);
			a = pick_addr(op, rand_word(), 6);
			send_req(v, op, a, rand_word(), fl);
		end

		req_valid <= 1'b0;
		flush <= 1'b0;
		repeat (3) @(posedge clk);
		if (fail_count == 0 && exp_q.size() == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("TESTBENCH FAILED");
			$fatal(1, "checks left unresolved at the end of the run");
		end
	end

endmodule

`default_nettype wire

//--- mem_subsys_top.f
+incdir+common
common/mips_mem_pkg.sv
mem_stage/mem_load_align.sv
mem_stage/mem_stage.sv
verilog/dbus_axil_master.sv
verilog/axil_data_ram.sv
verilog/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

//--- Makefile
# Verilator build and run for the memory subsystem testbench

TOP       ?= tb_mem_subsys
SEED      ?= 33582
VERILATOR ?= verilator
FLAGS     ?=
OBJ_DIR   ?= obj_dir
FILELIST  := mem_subsys_top.f

SRCS := $(shell grep -v '^+' $(FILELIST)) common/mips_mem_macros.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --timescale 1ns/1ns \
		-f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) $(FLAGS)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ns \
		-f $(FILELIST) --top-module $(TOP) $(FLAGS)

clean:
	rm -rf $(OBJ_DIR)
